//--- src/mipsPkg.sv
package mipsPkg;

	//////////////////////////////
	// basic types
	//////////////////////////////

	localparam int RegCount = 32;                 // architectural registers

	typedef logic [31:0] word_t;                  // data / address word
	typedef logic [4:0]  regAddr_t;               // register number

	//////////////////////////////
	// instruction encodings
	//////////////////////////////

	typedef enum logic [5:0] {
		OpRType = 6'h00,                          // add sub and or slt
		OpBeq   = 6'h04,
		OpAddi  = 6'h08,
		OpLw    = 6'h23,
		OpSw    = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		FnAdd = 6'h20,
		FnSub = 6'h22,
		FnAnd = 6'h24,
		FnOr  = 6'h25,
		FnSlt = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {
		AluAdd = 3'd0,                            // also the idle value
		AluSub = 3'd1,                            // beq compare too
		AluAnd = 3'd2,
		AluOr  = 3'd3,
		AluSlt = 3'd4                             // signed
	} aluOp_t;

	typedef enum logic [1:0] {
		FwdReg = 2'b00,                           // value read in decode
		FwdMem = 2'b01,                           // alu result in memory stage
		FwdWb  = 2'b10                            // result in writeback
	} fwdSel_t;

	//////////////////////////////
	// control and stage registers
	//////////////////////////////

	typedef struct packed {
		logic   regWrite;                         // writes rd/rt at writeback
		logic   memToReg;                         // result from data memory
		logic   memWrite;                         // store
		logic   branch;                           // beq
		logic   aluSrc;                           // b operand is the immediate
		logic   regDst;                           // destination rd, else rt
		aluOp_t aluOp;
	} ctrl_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    pcPlus4;                        // for the branch target
		word_t    rsVal;
		word_t    rtVal;
		word_t    imm;                            // sign extended
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
	} idEx_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    aluResult;                      // also the memory address
		word_t    storeData;
		regAddr_t writeReg;
		word_t    branchTarget;
		logic     zero;                           // operands equal
	} exMem_t;

	typedef struct packed {
		logic     regWrite;
		regAddr_t writeReg;
		word_t    result;                         // load data or alu result
	} memWb_t;

endpackage

//--- src/mipsDecoder.sv
`timescale 1ns/1ns

module mipsDecoder (
	input  mipsPkg::opcode_t opcode_i,            // instr[31:26]
	input  mipsPkg::funct_t  funct_i,             // instr[5:0]
	output mipsPkg::ctrl_t   ctrl_o
);
	import mipsPkg::*;

	ctrl_t ctrl;

	// funct decode for the R-type group
	always_comb begin
		ctrl = '0;                                // unknown -> no effect
		case (opcode_i)
			OpRType: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = 1'b1;             // writes rd
				case (funct_i)
					FnAdd: ctrl.aluOp = AluAdd;
					FnSub: ctrl.aluOp = AluSub;
					FnAnd: ctrl.aluOp = AluAnd;
					FnOr:  ctrl.aluOp = AluOr;
					FnSlt: ctrl.aluOp = AluSlt;
					default: begin
						ctrl = '0;                // also covers the all-zero nop
					end
				endcase
			end
			OpAddi: begin
				ctrl.regWrite = 1'b1;             // writes rt
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = AluAdd;
			end
			OpLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;             // base + offset
				ctrl.aluOp    = AluAdd;
			end
			OpSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;             // base + offset
				ctrl.aluOp    = AluAdd;
			end
			OpBeq: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp  = AluSub;             // zero flag -> equal
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

	assign ctrl_o = ctrl;

endmodule

//--- src/regFile.sv
`timescale 1ns/1ns

module regFile (
	input  logic              clk,
	input  logic              rstN_i,
	input  mipsPkg::regAddr_t raddrA_i,           // rs
	input  mipsPkg::regAddr_t raddrB_i,           // rt
	output mipsPkg::word_t    rdataA_o,
	output mipsPkg::word_t    rdataB_o,
	input  logic              we_i,               // from writeback
	input  mipsPkg::regAddr_t waddr_i,
	input  mipsPkg::word_t    wdata_i
);
	import mipsPkg::*;

	word_t regs [RegCount];

	// r0 reads zero, same-cycle write is passed through
	function automatic word_t readPort(regAddr_t addr);
		word_t val;
		if (addr == '0) val = '0;
		else if (we_i && (waddr_i == addr)) val = wdata_i;
		else val = regs[addr];
		return val;
	endfunction

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			for (int i = 0; i < RegCount; i++) regs[i] <= '0;
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;             // r0 write dropped
		end
	end

	always_comb begin
		rdataA_o = readPort(raddrA_i);
		rdataB_o = readPort(raddrB_i);
	end

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
	// decode
	input  mipsPkg::regAddr_t rsD_i,
	input  mipsPkg::regAddr_t rtD_i,
	// execute
	input  mipsPkg::regAddr_t rsE_i,
	input  mipsPkg::regAddr_t rtE_i,
	input  mipsPkg::regAddr_t writeRegE_i,
	input  logic              memToRegE_i,        // lw in execute
	// memory
	input  mipsPkg::regAddr_t writeRegM_i,
	input  logic              regWriteM_i,
	input  logic              branchTakenM_i,
	// writeback
	input  mipsPkg::regAddr_t writeRegW_i,
	input  logic              regWriteW_i,
	// control out
	output logic              stallF_o,
	output logic              stallD_o,
	output logic              flushD_o,
	output logic              flushE_o,
	output logic              flushM_o,
	output mipsPkg::fwdSel_t  forwardA_o,
	output mipsPkg::fwdSel_t  forwardB_o
);
	import mipsPkg::*;

	logic loadUse;

	// newest producer wins, r0 never forwarded
	function automatic fwdSel_t pickSource(regAddr_t src);
		fwdSel_t sel;
		sel = FwdReg;
		if (src != '0) begin
			if (regWriteM_i && (writeRegM_i == src)) sel = FwdMem;
			else if (regWriteW_i && (writeRegW_i == src)) sel = FwdWb;
		end
		return sel;
	endfunction

	always_comb begin
		forwardA_o = pickSource(rsE_i);
		forwardB_o = pickSource(rtE_i);
	end

	//////////////////////////////
	// stall and flush
	//////////////////////////////

	assign loadUse = memToRegE_i && (writeRegE_i != '0) &&
		((writeRegE_i == rsD_i) || (writeRegE_i == rtD_i));    // lw result not ready yet

	assign stallF_o = loadUse && !branchTakenM_i;              // taken branch overrides
	assign stallD_o = loadUse && !branchTakenM_i;
	assign flushD_o = branchTakenM_i;                          // kills fetch slot
	assign flushE_o = branchTakenM_i || loadUse;               // bubble on stall
	assign flushM_o = branchTakenM_i;

endmodule

//--- src/mipsAlu.sv
`timescale 1ns/1ns

module mipsAlu (
	input  mipsPkg::word_t  a_i,                  // rs after forwarding
	input  mipsPkg::word_t  b_i,                  // rt or immediate
	input  mipsPkg::aluOp_t op_i,
	output mipsPkg::word_t  result_o,
	output logic            zero_o                // feeds beq
);
	import mipsPkg::*;

	word_t sum;
	word_t diff;
	logic  lessThan;

	assign sum      = a_i + b_i;
	assign diff     = a_i - b_i;
	assign lessThan = $signed(a_i) < $signed(b_i);   // slt is signed

	always_comb begin
		case (op_i)
			AluAdd:  result_o = sum;
			AluSub:  result_o = diff;
			AluAnd:  result_o = a_i & b_i;
			AluOr:   result_o = a_i | b_i;
			AluSlt:  result_o = {31'b0, lessThan};
			default: result_o = '0;
		endcase
	end

	assign zero_o = (result_o == '0);

endmodule

//--- src/mipsCore.sv
`timescale 1ns/1ns

module mipsCore #(
	parameter mipsPkg::word_t ResetPc = 32'h0000_0000  // first fetch address
) (
	input  logic           clk,
	input  logic           rstN_i,
	// instruction fetch
	output mipsPkg::word_t pcF_o,
	input  mipsPkg::word_t instrF_i,
	// data memory, memory stage
	output mipsPkg::word_t memAddr_o,
	output mipsPkg::word_t memWData_o,
	output logic           memWe_o,               // one strobe per store
	input  mipsPkg::word_t memRData_i
);
	import mipsPkg::*;

	// hazard control
	logic    stallF, stallD;
	logic    flushD, flushE, flushM;
	fwdSel_t forwardA, forwardB;

	// fetch / decode
	word_t    pcF;
	word_t    pcPlus4F;
	word_t    instrD;
	word_t    pcPlus4D;
	regAddr_t rsD, rtD, rdD;
	word_t    immD;
	word_t    rsValD, rtValD;
	ctrl_t    ctrlD;

	// execute
	idEx_t    idEx;
	word_t    srcAE;
	word_t    rtFwdE;                             // also the store data
	word_t    srcBE;
	word_t    aluResultE;
	logic     zeroE;
	regAddr_t writeRegE;
	word_t    branchTargetE;

	// memory / writeback
	exMem_t   exMem;
	logic     branchTakenM;
	word_t    resultM;
	memWb_t   memWb;

	//////////////////////////////
	// fetch
	//////////////////////////////

	assign pcPlus4F = pcF + 32'd4;
	assign pcF_o    = pcF;

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) pcF <= ResetPc;
		else if (branchTakenM) pcF <= exMem.branchTarget;    // redirect
		else if (!stallF) pcF <= pcPlus4F;
	end

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			instrD   <= '0;
			pcPlus4D <= '0;
		end else if (flushD) begin
			instrD   <= '0;                       // all-zero decodes as nop
			pcPlus4D <= '0;
		end else if (!stallD) begin
			instrD   <= instrF_i;
			pcPlus4D <= pcPlus4F;
		end
	end

	//////////////////////////////
	// decode
	//////////////////////////////

	assign rsD  = instrD[25:21];
	assign rtD  = instrD[20:16];
	assign rdD  = instrD[15:11];
	assign immD = {{16{instrD[15]}}, instrD[15:0]};         // sign extend

	mipsDecoder decoder (
		.opcode_i (opcode_t'(instrD[31:26])),
		.funct_i  (funct_t'(instrD[5:0])),
		.ctrl_o   (ctrlD)
	);

	regFile rf (
		.clk      (clk),
		.rstN_i   (rstN_i),
		.raddrA_i (rsD),
		.raddrB_i (rtD),
		.rdataA_o (rsValD),
		.rdataB_o (rtValD),
		.we_i     (memWb.regWrite),
		.waddr_i  (memWb.writeReg),
		.wdata_i  (memWb.result)
	);

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) idEx <= '0;
		else if (flushE) idEx <= '0;                          // bubble or squash
		else idEx <= '{ctrl: ctrlD, pcPlus4: pcPlus4D, rsVal: rsValD, rtVal: rtValD,
			imm: immD, rs: rsD, rt: rtD, rd: rdD};
	end

	//////////////////////////////
	// execute
	//////////////////////////////

	function automatic word_t fwdMux(fwdSel_t sel, word_t regVal);
		word_t val;
		case (sel)
			FwdMem:  val = exMem.aluResult;       // lw never here, stall covers it
			FwdWb:   val = memWb.result;
			default: val = regVal;
		endcase
		return val;
	endfunction

	always_comb begin
		srcAE  = fwdMux(forwardA, idEx.rsVal);
		rtFwdE = fwdMux(forwardB, idEx.rtVal);
	end

	assign srcBE         = idEx.ctrl.aluSrc ? idEx.imm : rtFwdE;
	assign writeRegE     = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
	assign branchTargetE = idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};   // word offset

	mipsAlu alu (
		.a_i      (srcAE),
		.b_i      (srcBE),
		.op_i     (idEx.ctrl.aluOp),
		.result_o (aluResultE),
		.zero_o   (zeroE)
	);

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) exMem <= '0;
		else if (flushM) exMem <= '0;                         // squash on taken beq
		else exMem <= '{ctrl: idEx.ctrl, aluResult: aluResultE, storeData: rtFwdE,
			writeReg: writeRegE, branchTarget: branchTargetE, zero: zeroE};
	end

	//////////////////////////////
	// memory
	//////////////////////////////

	assign branchTakenM = exMem.ctrl.branch && exMem.zero;
	assign memAddr_o    = exMem.aluResult;
	assign memWData_o   = exMem.storeData;
	assign memWe_o      = exMem.ctrl.memWrite;
	assign resultM      = exMem.ctrl.memToReg ? memRData_i : exMem.aluResult;

	hazardUnit hazard (
		.rsD_i          (rsD),
		.rtD_i          (rtD),
		.rsE_i          (idEx.rs),
		.rtE_i          (idEx.rt),
		.writeRegE_i    (writeRegE),
		.memToRegE_i    (idEx.ctrl.memToReg),
		.writeRegM_i    (exMem.writeReg),
		.regWriteM_i    (exMem.ctrl.regWrite),
		.branchTakenM_i (branchTakenM),
		.writeRegW_i    (memWb.writeReg),
		.regWriteW_i    (memWb.regWrite),
		.stallF_o       (stallF),
		.stallD_o       (stallD),
		.flushD_o       (flushD),
		.flushE_o       (flushE),
		.flushM_o       (flushM),
		.forwardA_o     (forwardA),
		.forwardB_o     (forwardB)
	);

	//////////////////////////////
	// writeback
	//////////////////////////////

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) memWb <= '0;
		else memWb <= '{regWrite: exMem.ctrl.regWrite, writeReg: exMem.writeReg,
			result: resultM};
	end

endmodule

//--- bench/mipsCore_assertions.sv
`timescale 1ns/1ns

module mipsCoreAssertions (
	input logic           clk,
	input logic           rstN_i,
	input mipsPkg::word_t pcF_i,
	input mipsPkg::word_t memAddr_i,
	input logic           memWe_i
);

	// stage registers are cleared, so no store strobe
	noStoreInReset: assert property (@(posedge clk) !rstN_i |-> !memWe_i)
		else $error("store strobe high while reset is asserted");

	fetchAligned: assert property (@(posedge clk) pcF_i[1:0] == 2'b00)
		else $error("fetch address %h is not word aligned", pcF_i);

	storeAligned: assert property (@(posedge clk) disable iff (!rstN_i)
		memWe_i |-> (memAddr_i[1:0] == 2'b00))
		else $error("store address %h is not word aligned", memAddr_i);

endmodule

bind mipsCore mipsCoreAssertions coreChecks (
	.clk       (clk),
	.rstN_i    (rstN_i),
	.pcF_i     (pcF_o),
	.memAddr_i (memAddr_o),
	.memWe_i   (memWe_o)
);

//--- bench/mipsCoreTb.sv
`timescale 1ns/1ns

module mipsCoreTb;

	localparam logic [31:0] ResetAddr = 32'h0000_0040;      // nonzero first fetch
	localparam int ClkPeriod   = 40;
	localparam int ProgLen     = 32;                         // words of instruction memory
	localparam int NumRandom   = 50;
	localparam int NumProgs    = NumRandom + 1;              // directed program runs first
	localparam int DmemWords   = 64;
	localparam int QuietCycles = 20;
	localparam int WatchdogCycles = NumProgs * ProgLen * 8 + 200;

	// MIPS encodings
	localparam logic [5:0] OpR    = 6'h00;
	localparam logic [5:0] OpBeq  = 6'h04;
	localparam logic [5:0] OpAddi = 6'h08;
	localparam logic [5:0] OpLw   = 6'h23;
	localparam logic [5:0] OpSw   = 6'h2b;
	localparam logic [5:0] FnAdd  = 6'h20;
	localparam logic [5:0] FnSub  = 6'h22;
	localparam logic [5:0] FnAnd  = 6'h24;
	localparam logic [5:0] FnOr   = 6'h25;
	localparam logic [5:0] FnSlt  = 6'h2a;
	localparam logic [31:0] HaltInstr = {OpBeq, 5'd0, 5'd0, 16'hffff};   // beq r0,r0 to itself

	logic        clk;
	logic        rstN;
	logic [31:0] pcF;
	logic [31:0] instrF;
	logic [31:0] memAddr;
	logic [31:0] memWData;
	logic        memWe;
	logic [31:0] memRData;
	logic [31:0] fetchOffset;

	logic [31:0] imem [ProgLen];
	logic [31:0] dmem [DmemWords];
	logic [31:0] expAddr [$];                                // reference store list
	logic [31:0] expData [$];
	int          seenCount;
	logic [31:0] progSalt;
	logic [31:0] rngState = 32'hcba9;

	mipsCore #(.ResetPc(ResetAddr)) uut (
		.clk        (clk),
		.rstN_i     (rstN),
		.pcF_o      (pcF),
		.instrF_i   (instrF),
		.memAddr_o  (memAddr),
		.memWData_o (memWData),
		.memWe_o    (memWe),
		.memRData_i (memRData)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	//////////////////////////////
	// memory models
	//////////////////////////////

	assign fetchOffset = pcF - ResetAddr;

	always_comb begin
		if (fetchOffset[31:7] == '0) instrF = imem[fetchOffset[6:2]];   // 32 words
		else instrF = '0;                                    // nop outside the program
	end

	always_comb memRData = dmem[memAddr[7:2]];

	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < DmemWords; i++) dmem[i] <= fillWord(i);
		end else if (memWe) begin
			dmem[memAddr[7:2]] <= memWData;
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic logic [31:0] nextRand();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	function automatic logic [31:0] fillWord(int idx);
		return (32'(idx) * 32'h9e37_79b9) ^ progSalt;        // differs per word and program
	endfunction

	function automatic logic [31:0] encR(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd);
		return {OpR, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic abortRun(string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic checkValue(string what, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
			abortRun($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
				$time, what, actual, expected));
	endtask

	//////////////////////////////
	// programs
	//////////////////////////////

	function automatic void buildDirected();
		for (int k = 0; k < ProgLen; k++) imem[k] = '0;
		imem[0]  = encI(OpAddi, 5'd0, 5'd1, 16'h0080);       // data base
		imem[1]  = encI(OpAddi, 5'd0, 5'd2, 16'd5);
		imem[2]  = encI(OpAddi, 5'd2, 5'd3, 16'd7);          // from memory stage
		imem[3]  = encR(FnSub, 5'd3, 5'd2, 5'd4);            // both forward paths
		imem[4]  = encR(FnSlt, 5'd2, 5'd3, 5'd5);
		imem[5]  = encR(FnAnd, 5'd3, 5'd4, 5'd6);
		imem[6]  = encR(FnOr, 5'd6, 5'd5, 5'd7);
		imem[7]  = encI(OpSw, 5'd1, 5'd4, 16'd0);
		imem[8]  = encI(OpSw, 5'd1, 5'd7, 16'd4);
		imem[9]  = encI(OpLw, 5'd1, 5'd2, 16'd8);
		imem[10] = encR(FnAdd, 5'd2, 5'd2, 5'd3);            // load-use stall
		imem[11] = encI(OpSw, 5'd1, 5'd3, 16'd12);
		imem[12] = encI(OpAddi, 5'd0, 5'd0, 16'd9);          // r0 stays zero
		imem[13] = encI(OpSw, 5'd1, 5'd0, 16'd16);
		imem[14] = encI(OpBeq, 5'd5, 5'd5, 16'd1);           // taken
		imem[15] = encI(OpSw, 5'd1, 5'd6, 16'd20);           // skipped
		imem[16] = encI(OpBeq, 5'd0, 5'd5, 16'd1);           // not taken
		imem[17] = encI(OpSw, 5'd1, 5'd6, 16'd24);
		imem[18] = HaltInstr;
	endfunction

	function automatic void buildRandom();
		logic [31:0] r;
		logic [4:0]  dest;
		logic [4:0]  srcA;
		logic [4:0]  srcB;
		logic [15:0] memOff;
		logic [5:0]  fn;
		int          sel;
		int          off;
		imem[0] = encI(OpAddi, 5'd0, 5'd1, 16'h0080);        // r1 never written again
		for (int k = 1; k < ProgLen - 1; k++) begin
			r      = nextRand();
			sel    = int'(r[3:0]) % 10;
			dest   = {2'b00, r[6:4]};
			srcA   = {2'b00, r[10:8]};
			srcB   = {2'b00, r[14:12]};
			memOff = {8'd0, r[25:20], 2'b00} - 16'd128;      // 0x00..0xfc from base
			off    = int'(r[27:26]);
			if (dest == 5'd1) dest = 5'd0;                   // r0 writes now and then
			case (int'(r[18:16]) % 5)
				0: fn = FnAdd;
				1: fn = FnSub;
				2: fn = FnAnd;
				3: fn = FnOr;
				default: fn = FnSlt;
			endcase
			if (k + 1 + off > ProgLen - 1) off = ProgLen - 2 - k;   // stay before halt
			if (sel < 4) imem[k] = encR(fn, srcA, srcB, dest);
			else if (sel < 6) imem[k] = encI(OpAddi, srcA, dest, {{8{r[23]}}, r[23:16]});
			else if (sel == 6) imem[k] = encI(OpLw, 5'd1, dest, memOff);
			else if (sel < 9) imem[k] = encI(OpSw, 5'd1, srcB, memOff);
			else imem[k] = encI(OpBeq, srcA, srcB, off[15:0]);
		end
		imem[ProgLen - 1] = HaltInstr;
	endfunction

	// sequential ISA model, fills the expected store list
	function automatic void runReference();
		logic [31:0] regs [32];
		logic [31:0] mem [DmemWords];
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		int          pc;
		int          steps;
		for (int i = 0; i < 32; i++) regs[i] = '0;
		for (int i = 0; i < DmemWords; i++) mem[i] = fillWord(i);
		expAddr.delete();
		expData.delete();
		pc = 0;
		steps = 0;
		while (pc < ProgLen && imem[pc[4:0]] != HaltInstr && steps < 1000) begin
			ins  = imem[pc[4:0]];
			a    = regs[ins[25:21]];
			b    = regs[ins[20:16]];
			imm  = {{16{ins[15]}}, ins[15:0]};
			addr = a + imm;
			pc   = pc + 1;
			case (ins[31:26])
				OpR: begin
					case (ins[5:0])
						FnAdd: regs[ins[15:11]] = a + b;
						FnSub: regs[ins[15:11]] = a - b;
						FnAnd: regs[ins[15:11]] = a & b;
						FnOr:  regs[ins[15:11]] = a | b;
						FnSlt: regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: ;
					endcase
				end
				OpAddi: regs[ins[20:16]] = a + imm;
				OpLw:   regs[ins[20:16]] = mem[addr[7:2]];
				OpSw: begin
					mem[addr[7:2]] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
				end
				OpBeq: if (a == b) pc = pc + int'($signed(imm));
				default: ;
			endcase
			regs[0] = '0;                                    // hardwired zero
			steps++;
		end
	endfunction

	//////////////////////////////
	// store compare
	//////////////////////////////

	always @(posedge clk) begin
		if (!rstN) begin
			seenCount <= 0;
		end else if (memWe === 1'b1) begin
			if (seenCount >= expAddr.size()) begin
				abortRun($sformatf("store to %h at %0t ns was not expected by the reference",
					memAddr, $time));
			end else begin
				checkValue("store address", memAddr, expAddr[seenCount]);
				checkValue("store data", memWData, expData[seenCount]);
				seenCount <= seenCount + 1;
			end
		end
	end

	initial begin
		repeat (WatchdogCycles) @(posedge clk);
		abortRun("timeout: the core did not finish its stores in time");
	end

	initial begin
		rstN <= 1'b0;
		for (int p = 0; p < NumProgs; p++) begin
			@(posedge clk);
			rstN <= 1'b0;
			progSalt = nextRand();
			if (p == 0) buildDirected();
			else buildRandom();
			runReference();
			repeat (10) @(posedge clk);
			checkValue("fetch address in reset", pcF, ResetAddr);
			rstN <= 1'b1;
			while (seenCount < expAddr.size()) @(posedge clk);
			repeat (QuietCycles) @(posedge clk);               // quiet tail, halt loop only
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- mipsCore.f
src/mipsPkg.sv
src/mipsDecoder.sv
src/regFile.sv
src/hazardUnit.sv
src/mipsAlu.sv
src/mipsCore.sv
bench/mipsCore_assertions.sv
bench/mipsCoreTb.sv

//--- run.sh
#!/bin/sh
# build the mipsCore testbench with Verilator and run it
# the exit status is the simulator's own
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module mipsCoreTb \
	-f mipsCore.f \
	-o simMipsCore \
	&& ./obj_dir/simMipsCore \
	|| { echo "build or simulation returned an error"; exit 1; }
